//--- du_pkg.sv
////////////////////
// Debug unit shared definitions
// Widths and word types, address map,
// breakpoint condition codes, opcodes
// and cause encoding
////////////////////

`default_nettype none

package du_pkg;

  ////////////////////
  // Widths and word types
  ////////////////////
  localparam int DBG_ADDR_W = 16;
  localparam int DU_ADDR_W  = 12;

  typedef logic [31:0]                   xlen_t;
  typedef logic [31:0]                   instr_t;
  typedef logic [DBG_ADDR_W-1:0]         dbg_addr_t;
  typedef logic [DU_ADDR_W-1:0]          du_addr_t;
  typedef logic [DBG_ADDR_W-DU_ADDR_W-1:0] bank_t;
  // Traps in 15..0, interrupts in 31..16
  typedef logic [31:0]                   exc_t;
  typedef logic [11:0]                   mem_exc_t;

  // Fixed breakpoint count
  localparam int NUM_BP = 3;

  ////////////////////
  // Address map
  ////////////////////
  localparam bank_t BANK_INTERNAL = 4'h0;
  localparam bank_t BANK_GPRS     = 4'h1;

  // Internal bank
  localparam du_addr_t REG_CTRL    = 12'h000;
  localparam du_addr_t REG_HIT     = 12'h001;
  localparam du_addr_t REG_IE      = 12'h002;
  localparam du_addr_t REG_CAUSE   = 12'h003;
  // Slot n at these plus 2n
  localparam du_addr_t REG_BPCTRL0 = 12'h010;
  localparam du_addr_t REG_BPDATA0 = 12'h011;

  // GPR bank
  localparam du_addr_t GPR_LAST = 12'h01F;
  localparam du_addr_t REG_NPC  = 12'h200;
  localparam du_addr_t REG_PPC  = 12'h201;

  ////////////////////
  // Register bit fields
  ////////////////////
  localparam int CTRL_INSTR_ENA  = 0;
  localparam int CTRL_BRANCH_ENA = 1;
  localparam int HIT_INSTR       = 0;
  localparam int HIT_BRANCH      = 1;
  localparam int HIT_BP_LSB      = 4;
  localparam int BPCTRL_IMPL     = 0;
  localparam int BPCTRL_ENA      = 1;
  localparam int BPCTRL_CC_LSB   = 4;

  // Breakpoint condition
  typedef enum logic [2:0] {
    FETCH    = 3'd0,
    LD_ADR   = 3'd4,
    ST_ADR   = 3'd5,
    LDST_ADR = 3'd7
  } bp_cc_e;

  // Opcode field, instr[6:2]
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;

  // addi x0,x0,0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

  ////////////////////
  // Cause encoding
  ////////////////////
  localparam int NUM_TRAPS = 16;
  typedef logic [3:0] cause_idx_t;
  // Interrupt flag in cause
  localparam xlen_t CAUSE_INTR = 32'h8000_0000;

endpackage

`default_nettype wire

//--- du_host_port.sv
////////////////////
// Debug port front end
// Bank decode, ack pipeline, write pulses,
// stall/flush toward the core, readback
////////////////////

`timescale 1ns/10ps
`default_nettype none

module du_host_port (
  input  wire                    clk,
  input  wire                    rstn,
  // Host side
  input  wire                    dbg_stall,
  input  wire                    dbg_strb,
  input  wire                    dbg_we,
  input  wire du_pkg::dbg_addr_t dbg_addr,
  input  wire du_pkg::xlen_t     dbg_dati,
  output du_pkg::xlen_t          dbg_dato,
  output logic                   dbg_ack,
  // Core side
  input  wire                    ex_stall,
  input  wire du_pkg::xlen_t     du_dati_rf,
  input  wire du_pkg::xlen_t     id_pc,
  input  wire du_pkg::xlen_t     ex_pc,
  input  wire du_pkg::xlen_t     bu_nxt_pc,
  input  wire                    bu_flush,
  input  wire du_pkg::exc_t      du_exceptions,
  output logic                   du_stall,
  output logic                   du_stall_dly,
  output logic                   du_flush,
  output logic                   du_we_rf,
  output logic                   du_we_pc,
  output du_pkg::du_addr_t       du_addr,
  output du_pkg::xlen_t          du_dato,
  // Internal register bank
  input  wire du_pkg::xlen_t     internal_rdata,
  output logic                   we_internal
);

  du_pkg::bank_t    bank;
  du_pkg::du_addr_t offset;
  logic             sel_internal;
  logic             sel_gprs;
  logic             gpr_range;
  logic             strb_dly;
  logic             access;
  logic             host_we;
  logic [2:0]       du_ack;

  ////////////////////
  // Address decode
  ////////////////////
  assign bank         = dbg_addr[du_pkg::DBG_ADDR_W-1:du_pkg::DU_ADDR_W];
  assign offset       = dbg_addr[du_pkg::DU_ADDR_W-1:0];
  assign sel_internal = (bank == du_pkg::BANK_INTERNAL);
  assign sel_gprs     = (bank == du_pkg::BANK_GPRS);
  assign gpr_range    = (offset <= du_pkg::GPR_LAST);

  // GPR bank only reachable while the core is stalled
  assign access  = dbg_strb & (dbg_stall | sel_internal);
  // Write on first strobe cycle only
  assign host_we = access & ~strb_dly & dbg_we;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      strb_dly <= 1'b0;
    else
      strb_dly <= dbg_strb;
  end

  ////////////////////
  // Acknowledge
  ////////////////////
  // Fills from the top, ack when full, then clears
  // Frozen while ex_stall is high
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      du_ack <= 3'b000;
    else if (!ex_stall)
      du_ack <= {3{access & ~dbg_ack}} & {1'b1, du_ack[2:1]};
  end

  assign dbg_ack = du_ack[0];

  ////////////////////
  // Core interface
  ////////////////////
  assign du_stall = dbg_stall;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      du_stall_dly <= 1'b0;
    else
      du_stall_dly <= dbg_stall;
  end

  // Stall release with an exception pending
  assign du_flush = du_stall_dly & ~dbg_stall & (|du_exceptions);

  // Address and write data follow the port every cycle
  always_ff @(posedge clk)
  begin
    du_addr <= offset;
    du_dato <= dbg_dati;
  end

  // One-cycle write pulses, at most one per access
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      du_we_rf    <= 1'b0;
      du_we_pc    <= 1'b0;
      we_internal <= 1'b0;
    end
    else
    begin
      du_we_rf    <= host_we & sel_gprs & gpr_range;
      du_we_pc    <= host_we & sel_gprs & (offset == du_pkg::REG_NPC);
      we_internal <= host_we & sel_internal;
    end
  end

  ////////////////////
  // Readback
  ////////////////////
  // Internal word comes from the registered address
  always_ff @(posedge clk)
  begin
    if (sel_internal)
      dbg_dato <= internal_rdata;
    else if (sel_gprs && gpr_range)
      dbg_dato <= du_dati_rf;
    else if (sel_gprs && offset == du_pkg::REG_NPC)
      dbg_dato <= bu_flush ? bu_nxt_pc : id_pc;
    else if (sel_gprs && offset == du_pkg::REG_PPC)
      dbg_dato <= ex_pc;
    else
      dbg_dato <= '0;
  end

endmodule

`default_nettype wire

//--- du_regs.sv
////////////////////
// Debug unit internal registers
// CTRL, HIT, IE and CAUSE, single-step and
// branch break, read mux and break output
////////////////////

`timescale 1ns/10ps
`default_nettype none

module du_regs (
  input  wire                    clk,
  input  wire                    rstn,
  // Host writes
  input  wire                    we_internal,
  input  wire du_pkg::du_addr_t  du_addr,
  input  wire du_pkg::xlen_t     du_dato,
  // Core status
  input  wire du_pkg::instr_t    if_instr,
  input  wire du_pkg::exc_t      du_exceptions,
  input  wire                    ex_stall,
  input  wire                    du_stall,
  input  wire                    du_flush,
  input  wire                    bu_flush,
  input  wire                    st_flush,
  // Breakpoint slots
  input  wire [du_pkg::NUM_BP-1:0] bp_hit,
  input  wire du_pkg::xlen_t [du_pkg::NUM_BP-1:0] bp_rdata,
  output du_pkg::xlen_t          internal_rdata,
  output du_pkg::exc_t           du_ie,
  output logic                   dbg_bp
);

  logic                      ctrl_instr_ena;
  logic                      ctrl_branch_ena;
  logic                      hit_instr;
  logic                      hit_branch;
  logic [du_pkg::NUM_BP-1:0] hit_bp;
  du_pkg::exc_t              ie;
  du_pkg::xlen_t             cause;
  du_pkg::xlen_t             hit_word;
  du_pkg::xlen_t             ctrl_word;
  du_pkg::xlen_t             slot_rdata;
  du_pkg::cause_idx_t        trap_idx;
  du_pkg::cause_idx_t        intr_idx;
  logic                      instr_break;
  logic                      branch_break;

  // Single-step on any real instruction
  assign instr_break  = ctrl_instr_ena & (if_instr != du_pkg::INSTR_NOP);
  assign branch_break = ctrl_branch_ena & (if_instr[6:2] == du_pkg::OPC_BRANCH);

  ////////////////////
  // CTRL and IE
  ////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      ctrl_instr_ena  <= 1'b0;
      ctrl_branch_ena <= 1'b0;
      ie              <= '0;
    end
    else if (we_internal)
    begin
      if (du_addr == du_pkg::REG_CTRL)
      begin
        ctrl_instr_ena  <= du_dato[du_pkg::CTRL_INSTR_ENA];
        ctrl_branch_ena <= du_dato[du_pkg::CTRL_BRANCH_ENA];
      end
      if (du_addr == du_pkg::REG_IE) ie <= du_dato;
    end
  end

  assign du_ie = ie;

  ////////////////////
  // HIT
  ////////////////////
  // Sticky until written, host write wins
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      hit_instr  <= 1'b0;
      hit_branch <= 1'b0;
      hit_bp     <= '0;
    end
    else if (we_internal && du_addr == du_pkg::REG_HIT)
    begin
      hit_instr  <= du_dato[du_pkg::HIT_INSTR];
      hit_branch <= du_dato[du_pkg::HIT_BRANCH];
      hit_bp     <= du_dato[du_pkg::HIT_BP_LSB +: du_pkg::NUM_BP];
    end
    else
    begin
      hit_instr  <= hit_instr | instr_break;
      hit_branch <= hit_branch | branch_break;
      hit_bp     <= hit_bp | bp_hit;
    end
  end

  ////////////////////
  // CAUSE
  ////////////////////
  // Lowest set bit wins in each half
  always_comb
  begin
    trap_idx = '0;
    intr_idx = '0;
    for (int i = du_pkg::NUM_TRAPS - 1; i >= 0; i--)
    begin
      if (du_exceptions[i]) trap_idx = du_pkg::cause_idx_t'(i);
      if (du_exceptions[i + du_pkg::NUM_TRAPS]) intr_idx = du_pkg::cause_idx_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      cause <= '0;
    else if (we_internal && du_addr == du_pkg::REG_CAUSE)
      cause <= du_dato;
    else if (|du_exceptions[du_pkg::NUM_TRAPS-1:0])
      cause <= du_pkg::xlen_t'(trap_idx);
    else if (|du_exceptions[31:du_pkg::NUM_TRAPS])
      cause <= du_pkg::CAUSE_INTR | du_pkg::xlen_t'(intr_idx);
  end

  ////////////////////
  // Read mux
  ////////////////////
  always_comb
  begin
    ctrl_word = '0;
    ctrl_word[du_pkg::CTRL_INSTR_ENA]  = ctrl_instr_ena;
    ctrl_word[du_pkg::CTRL_BRANCH_ENA] = ctrl_branch_ena;
    hit_word = '0;
    hit_word[du_pkg::HIT_INSTR]  = hit_instr;
    hit_word[du_pkg::HIT_BRANCH] = hit_branch;
    hit_word[du_pkg::HIT_BP_LSB +: du_pkg::NUM_BP] = hit_bp;
  end

  // Unaddressed slots return zero
  always_comb
  begin
    slot_rdata = '0;
    for (int n = 0; n < du_pkg::NUM_BP; n++)
      slot_rdata = slot_rdata | bp_rdata[n];
    case (du_addr)
      du_pkg::REG_CTRL:  internal_rdata = ctrl_word;
      du_pkg::REG_HIT:   internal_rdata = hit_word;
      du_pkg::REG_IE:    internal_rdata = ie;
      du_pkg::REG_CAUSE: internal_rdata = cause;
      default:           internal_rdata = slot_rdata;
    endcase
  end

  // Break to host, held off while the core is busy
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      dbg_bp <= 1'b0;
    else
      dbg_bp <= ~ex_stall & ~du_stall & ~du_flush & ~bu_flush & ~st_flush &
                ((|du_exceptions) | (|hit_word));
  end

endmodule

`default_nettype wire

//--- du_bp_slot.sv
////////////////////
// One hardware breakpoint
// Control and match registers, readback,
// combinational hit detect
////////////////////

`timescale 1ns/10ps
`default_nettype none

module du_bp_slot #(
  parameter int slot_idx = 0
) (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    we_internal,
  input  wire du_pkg::du_addr_t  du_addr,
  input  wire du_pkg::xlen_t     du_dato,
  // Fetch side
  input  wire du_pkg::xlen_t     if_pc,
  input  wire                    bu_flush,
  input  wire                    st_flush,
  // Memory side
  input  wire du_pkg::instr_t    mem_instr,
  input  wire du_pkg::mem_exc_t  mem_exception,
  input  wire du_pkg::xlen_t     mem_memadr,
  input  wire                    dmem_ack,
  output logic                   hit,
  output du_pkg::xlen_t          rdata
);

  du_pkg::du_addr_t ctrl_addr;
  du_pkg::du_addr_t data_addr;
  logic             ena;
  du_pkg::bp_cc_e   cc;
  du_pkg::xlen_t    match_val;
  du_pkg::xlen_t    ctrl_word;
  logic             mem_read;
  logic             mem_write;
  logic             adr_match;

  // Two words per slot
  assign ctrl_addr = du_pkg::du_addr_t'(du_pkg::REG_BPCTRL0 + 2 * slot_idx);
  assign data_addr = du_pkg::du_addr_t'(du_pkg::REG_BPDATA0 + 2 * slot_idx);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      ena       <= 1'b0;
      cc        <= du_pkg::FETCH;
      match_val <= '0;
    end
    else if (we_internal)
    begin
      if (du_addr == ctrl_addr)
      begin
        ena <= du_dato[du_pkg::BPCTRL_ENA];
        cc  <= du_pkg::bp_cc_e'(du_dato[du_pkg::BPCTRL_CC_LSB +: 3]);
      end
      if (du_addr == data_addr) match_val <= du_dato;
    end
  end

  // Readback, implemented bit always set
  always_comb
  begin
    ctrl_word = '0;
    ctrl_word[du_pkg::BPCTRL_IMPL] = 1'b1;
    ctrl_word[du_pkg::BPCTRL_ENA]  = ena;
    ctrl_word[du_pkg::BPCTRL_CC_LSB +: 3] = cc;
    if (du_addr == ctrl_addr)
      rdata = ctrl_word;
    else if (du_addr == data_addr)
      rdata = match_val;
    else
      rdata = '0;
  end

  ////////////////////
  // Hit detect
  ////////////////////
  assign mem_read  = ~(|mem_exception) & (mem_instr[6:2] == du_pkg::OPC_LOAD);
  assign mem_write = ~(|mem_exception) & (mem_instr[6:2] == du_pkg::OPC_STORE);
  assign adr_match = dmem_ack & (mem_memadr == match_val);

  always_comb
  begin
    if (!ena)
      hit = 1'b0;
    else
      case (cc)
        du_pkg::FETCH:    hit = (if_pc == match_val) & ~bu_flush & ~st_flush;
        du_pkg::LD_ADR:   hit = adr_match & mem_read;
        du_pkg::ST_ADR:   hit = adr_match & mem_write;
        du_pkg::LDST_ADR: hit = adr_match & (mem_read | mem_write);
        default:          hit = 1'b0;
      endcase
  end

endmodule

`default_nettype wire

//--- riscv_du.sv
////////////////////
// Debug unit top level
// Host port, internal registers and
// the breakpoint slots
////////////////////

`timescale 1ns/10ps
`default_nettype none

module riscv_du (
  input  wire                    clk,
  input  wire                    rstn,
  // Debug port
  input  wire                    dbg_stall,
  input  wire                    dbg_strb,
  input  wire                    dbg_we,
  input  wire du_pkg::dbg_addr_t dbg_addr,
  input  wire du_pkg::xlen_t     dbg_dati,
  output wire du_pkg::xlen_t     dbg_dato,
  output wire                    dbg_ack,
  output wire                    dbg_bp,
  // Core control
  output wire                    du_stall,
  output wire                    du_stall_dly,
  output wire                    du_flush,
  output wire                    du_we_rf,
  output wire                    du_we_pc,
  output wire du_pkg::du_addr_t  du_addr,
  output wire du_pkg::xlen_t     du_dato,
  output wire du_pkg::exc_t      du_ie,
  // Core status
  input  wire du_pkg::xlen_t     du_dati_rf,
  input  wire du_pkg::xlen_t     if_pc,
  input  wire du_pkg::xlen_t     id_pc,
  input  wire du_pkg::xlen_t     ex_pc,
  input  wire du_pkg::xlen_t     bu_nxt_pc,
  input  wire                    bu_flush,
  input  wire                    st_flush,
  input  wire du_pkg::instr_t    if_instr,
  input  wire du_pkg::instr_t    mem_instr,
  input  wire du_pkg::mem_exc_t  mem_exception,
  input  wire du_pkg::xlen_t     mem_memadr,
  input  wire                    dmem_ack,
  input  wire                    ex_stall,
  input  wire du_pkg::exc_t      du_exceptions
);

  wire                                    we_internal;
  wire du_pkg::xlen_t                     internal_rdata;
  wire [du_pkg::NUM_BP-1:0]               bp_hit;
  wire du_pkg::xlen_t [du_pkg::NUM_BP-1:0] bp_rdata;

  du_host_port u_host_port (
    .clk            (clk),
    .rstn           (rstn),
    .dbg_stall      (dbg_stall),
    .dbg_strb       (dbg_strb),
    .dbg_we         (dbg_we),
    .dbg_addr       (dbg_addr),
    .dbg_dati       (dbg_dati),
    .dbg_dato       (dbg_dato),
    .dbg_ack        (dbg_ack),
    .ex_stall       (ex_stall),
    .du_dati_rf     (du_dati_rf),
    .id_pc          (id_pc),
    .ex_pc          (ex_pc),
    .bu_nxt_pc      (bu_nxt_pc),
    .bu_flush       (bu_flush),
    .du_exceptions  (du_exceptions),
    .du_stall       (du_stall),
    .du_stall_dly   (du_stall_dly),
    .du_flush       (du_flush),
    .du_we_rf       (du_we_rf),
    .du_we_pc       (du_we_pc),
    .du_addr        (du_addr),
    .du_dato        (du_dato),
    .internal_rdata (internal_rdata),
    .we_internal    (we_internal)
  );

  du_regs u_regs (
    .clk            (clk),
    .rstn           (rstn),
    .we_internal    (we_internal),
    .du_addr        (du_addr),
    .du_dato        (du_dato),
    .if_instr       (if_instr),
    .du_exceptions  (du_exceptions),
    .ex_stall       (ex_stall),
    .du_stall       (du_stall),
    .du_flush       (du_flush),
    .bu_flush       (bu_flush),
    .st_flush       (st_flush),
    .bp_hit         (bp_hit),
    .bp_rdata       (bp_rdata),
    .internal_rdata (internal_rdata),
    .du_ie          (du_ie),
    .dbg_bp         (dbg_bp)
  );

  // One slot per breakpoint, index sets its addresses
  for (genvar n = 0; n < du_pkg::NUM_BP; n++)
  begin : gen_bp
    du_bp_slot #(
      .slot_idx (n)
    ) u_slot (
      .clk           (clk),
      .rstn          (rstn),
      .we_internal   (we_internal),
      .du_addr       (du_addr),
      .du_dato       (du_dato),
      .if_pc         (if_pc),
      .bu_flush      (bu_flush),
      .st_flush      (st_flush),
      .mem_instr     (mem_instr),
      .mem_exception (mem_exception),
      .mem_memadr    (mem_memadr),
      .dmem_ack      (dmem_ack),
      .hit           (bp_hit[n]),
      .rdata         (bp_rdata[n])
    );
  end

endmodule

`default_nettype wire

//--- du_assertions.sv
////////////////////
// Host port checks
// Ack spacing, write pulse shape
////////////////////

`timescale 1ns/10ps
`default_nettype none

module du_assertions (
  input wire clk,
  input wire rstn,
  input wire dbg_strb,
  input wire dbg_ack,
  input wire du_we_rf,
  input wire du_we_pc,
  input wire we_internal
);

  // Ack is a single-cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |=> !dbg_ack)
    else $error("dbg_ack high on two consecutive cycles");

  ////////////////////
  // Write pulses
  ////////////////////
  rf_pulse: assert property (@(posedge clk) disable iff (!rstn)
    du_we_rf |=> !du_we_rf)
    else $error("du_we_rf longer than one cycle");

  pc_pulse: assert property (@(posedge clk) disable iff (!rstn)
    du_we_pc |=> !du_we_pc)
    else $error("du_we_pc longer than one cycle");

  int_pulse: assert property (@(posedge clk) disable iff (!rstn)
    we_internal |=> !we_internal)
    else $error("we_internal longer than one cycle");

  // At most one target per write
  we_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({du_we_rf, du_we_pc, we_internal}))
    else $error("more than one write pulse at once");

  // Three-stage pipeline, nothing early
  ack_not_early: assert property (@(posedge clk) disable iff (!rstn)
    $rose(dbg_strb) |-> !dbg_ack ##1 !dbg_ack ##1 !dbg_ack)
    else $error("dbg_ack within two cycles of the strobe");

endmodule

bind du_host_port du_assertions u_assertions (
  .clk         (clk),
  .rstn        (rstn),
  .dbg_strb    (dbg_strb),
  .dbg_ack     (dbg_ack),
  .du_we_rf    (du_we_rf),
  .du_we_pc    (du_we_pc),
  .we_internal (we_internal)
);

`default_nettype wire

//--- du_tb.sv
////////////////////
// Debug unit testbench
// Clock, reset, LFSR, stimulus table,
// row loop, checks, watchdog, summary
////////////////////

`timescale 1ns/10ps
`default_nettype none

module du_tb;

  // Row kinds
  localparam int K_WR = 0, K_RD = 1, K_EV = 2, K_NOACK = 3, K_LAT = 4, K_IE = 5, K_FLUSH = 6;
  // Core input scenarios
  localparam int C_IDLE = 0, C_STALL = 1, C_STALL_BF = 2, C_FETCH = 3, C_FETCH_FL = 4;
  localparam int C_LOAD = 5, C_STORE = 6, C_LOAD_NOACK = 7, C_LOAD_EXC = 8;
  localparam int C_INSTR = 9, C_BRANCH = 10, C_EXC = 11;
  // Core side values seen by GPR reads
  localparam logic [31:0] RF_VAL = 32'h1234_5678, ID_PC = 32'h0000_2a40;
  localparam logic [31:0] EX_PC = 32'h0000_2a3c, NXT_PC = 32'h0000_3f00;

  logic clk, rstn, dbg_stall, dbg_strb, dbg_we, bu_flush, st_flush, dmem_ack, ex_stall;
  logic [15:0] dbg_addr;
  logic [11:0] mem_exception;
  logic [31:0] dbg_dati, du_dati_rf, if_pc, id_pc, ex_pc, bu_nxt_pc;
  logic [31:0] if_instr, mem_instr, mem_memadr, du_exceptions;
  wire [31:0] dbg_dato, du_dato, du_ie;
  wire [11:0] du_addr;
  wire dbg_ack, dbg_bp, du_stall, du_stall_dly, du_flush, du_we_rf, du_we_pc;

  // Stimulus table with one entry per row
  int kind_q[$], core_q[$];
  logic [15:0] addr_q[$];
  logic [31:0] data_q[$], exp_q[$];
  string name_q[$];
  int n_rows = 0, errors = 0, rf_cnt, pc_cnt;
  bit row_err;
  logic [31:0] lfsr = 32'hc91c, cap_data;
  logic [11:0] cap_addr;

  riscv_du uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic fb;
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  // Lowest trap index, else lowest interrupt index with bit 31
  function automatic logic [31:0] cause_of(logic [31:0] v);
    for (int i = 0; i < 16; i++)
      if (v[i]) return i;
    for (int i = 16; i < 32; i++)
      if (v[i]) return 32'h8000_0000 | (i - 16);
    return 0;
  endfunction

  task automatic add_row(int k, logic [15:0] a, logic [31:0] d, int c, logic [31:0] e,
                         string n);
    kind_q.push_back(k);
    addr_q.push_back(a);
    data_q.push_back(d);
    core_q.push_back(c);
    exp_q.push_back(e);
    name_q.push_back(n);
  endtask

  task automatic check_val(string sig, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
      row_err = 1;
    end
  endtask

  task automatic check_true(bit ok, string msg);
    assert (ok)
    else
    begin
      $display("Error at %0t: %s", $time, msg);
      errors++;
      row_err = 1;
    end
  endtask

  // Puts all core inputs into one scenario
  task automatic apply_core(int c, logic [31:0] v);
    dbg_stall = (c == C_STALL || c == C_STALL_BF);
    bu_flush = (c == C_STALL_BF || c == C_FETCH_FL);
    st_flush = 1'b0;
    du_dati_rf = RF_VAL;
    id_pc = ID_PC;
    ex_pc = EX_PC;
    bu_nxt_pc = NXT_PC;
    if_pc = (c == C_FETCH || c == C_FETCH_FL) ? v : 32'h0;
    if_instr = (c == C_INSTR) ? 32'h0000_0033 : (c == C_BRANCH) ? 32'h0000_0063 : 32'h13;
    mem_instr = (c == C_STORE) ? 32'h0000_2023 : 32'h0000_2003;
    mem_memadr = (c >= C_LOAD && c <= C_LOAD_EXC) ? v : 32'h0;
    dmem_ack = (c == C_LOAD || c == C_STORE || c == C_LOAD_EXC);
    mem_exception = (c == C_LOAD_EXC) ? 12'h004 : 12'h000;
    du_exceptions = (c == C_EXC) ? v : 32'h0;
  endtask

  // Write pulse monitor sampled away from the active edge
  always @(negedge clk)
  begin
    if (du_we_rf || du_we_pc)
    begin
      rf_cnt += du_we_rf;
      pc_cnt += du_we_pc;
      cap_addr = du_addr;
      cap_data = du_dato;
    end
  end

  // Strobe held through to ack while edges are counted
  task automatic do_access(bit we, logic [15:0] a, logic [31:0] d, int stall_cyc,
                           output logic [31:0] got, output int lat);
    bit ok;
    ok = 0;
    lat = 0;
    dbg_strb = 1'b1;
    dbg_we = we;
    dbg_addr = a;
    dbg_dati = d;
    ex_stall = (stall_cyc > 0);
    while (lat < 20 && !ok)
    begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      if (lat >= stall_cyc) ex_stall = 1'b0;
      if (dbg_ack)
      begin
        ok = 1;
        got = dbg_dato;
      end
    end
    dbg_strb = 1'b0;
    dbg_we = 1'b0;
    check_true(ok, "no acknowledge within 20 cycles");
  endtask

  task automatic run_row(int r);
    logic [31:0] got;
    int lat;
    bit seen;
    apply_core(core_q[r], data_q[r]);
    case (kind_q[r])
      K_WR:
      begin
        rf_cnt = 0;
        pc_cnt = 0;
        do_access(1'b1, addr_q[r], data_q[r], 0, got, lat);
        check_val("ack latency", lat, 3);
        check_val("du_we_rf count", rf_cnt, exp_q[r] == 1);
        check_val("du_we_pc count", pc_cnt, exp_q[r] == 2);
        if (exp_q[r] != 0)
        begin
          check_val("du_addr", cap_addr, addr_q[r][11:0]);
          check_val("du_dato", cap_data, data_q[r]);
        end
      end
      K_RD:
      begin
        do_access(1'b0, addr_q[r], 32'h0, 0, got, lat);
        check_val("ack latency", lat, 3);
        check_val("dbg_dato", got, exp_q[r]);
      end
      K_LAT:
      begin
        do_access(1'b0, addr_q[r], 32'h0, data_q[r], got, lat);
        check_val("ack latency", lat, exp_q[r]);
      end
      K_IE:
        check_val("du_ie", du_ie, exp_q[r]);
      K_NOACK:
      begin
        seen = 0;
        dbg_strb = 1'b1;
        dbg_addr = addr_q[r];
        repeat (10)
        begin
          @(negedge clk);
          seen |= dbg_ack;
        end
        dbg_strb = 1'b0;
        check_true(!seen, "GPR access acknowledged without dbg_stall");
      end
      K_EV:
      begin
        // Inputs held for one cycle before the break line is watched
        seen = 0;
        for (int k = 0; k < 5 && !seen; k++)
        begin
          @(negedge clk);
          seen = dbg_bp;
          if (k == 0) apply_core(C_IDLE, 32'h0);
        end
        check_val("dbg_bp", seen, exp_q[r]);
      end
      K_FLUSH:
      begin
        du_exceptions = data_q[r];
        @(negedge clk);
        check_val("du_stall", du_stall, 1);
        check_val("du_stall_dly", du_stall_dly, 1);
        dbg_stall = 1'b0;
        #2;
        check_val("du_stall", du_stall, 0);
        check_val("du_stall_dly", du_stall_dly, 1);
        check_val("du_flush", du_flush, exp_q[r]);
        @(negedge clk);
        check_val("du_stall_dly", du_stall_dly, 0);
        check_val("du_flush", du_flush, 0);
      end
      default:
        check_true(0, "unknown row kind");
    endcase
    @(negedge clk);
    apply_core(C_IDLE, 32'h0);
    repeat (2) @(negedge clk);
  endtask

  task automatic build_table();
    logic [31:0] v, pc_r, adr_r, exc_r;
    ////////////////////
    // Internal registers
    v = rand_word();
    add_row(K_WR, 16'h0000, v, C_IDLE, 0, "ctrl_write");
    add_row(K_RD, 16'h0000, 0, C_IDLE, v & 32'h3, "ctrl_read");
    add_row(K_WR, 16'h0000, 0, C_IDLE, 0, "ctrl_clear");
    v = rand_word();
    add_row(K_WR, 16'h0002, v, C_IDLE, 0, "ie_write");
    add_row(K_RD, 16'h0002, 0, C_IDLE, v, "ie_read");
    add_row(K_IE, 16'h0000, 0, C_IDLE, v, "ie_output");
    v = rand_word();
    add_row(K_WR, 16'h0015, v, C_IDLE, 0, "bp2_data_write");
    add_row(K_RD, 16'h0015, 0, C_IDLE, v, "bp2_data_read");
    add_row(K_RD, 16'h0014, 0, C_IDLE, 32'h1, "bp2_ctrl_impl");
    ////////////////////
    // GPR bank and ack timing
    add_row(K_WR, 16'h1005, rand_word(), C_STALL, 1, "gpr_write");
    add_row(K_WR, 16'h1200, rand_word(), C_STALL, 2, "npc_write");
    add_row(K_RD, 16'h1007, 0, C_STALL, RF_VAL, "gpr_read");
    add_row(K_RD, 16'h1200, 0, C_STALL, ID_PC, "npc_read_id");
    add_row(K_RD, 16'h1200, 0, C_STALL_BF, NXT_PC, "npc_read_branch");
    add_row(K_RD, 16'h1201, 0, C_STALL, EX_PC, "ppc_read");
    add_row(K_NOACK, 16'h1003, 0, C_IDLE, 0, "gpr_no_stall");
    add_row(K_LAT, 16'h0002, 0, C_IDLE, 3, "ack_latency");
    add_row(K_LAT, 16'h0002, 4, C_IDLE, 7, "ack_ex_stall");
    ////////////////////
    // Fetch breakpoint on slot 1
    v = rand_word();
    pc_r = {v[31:2], 2'b00} | 32'h100;
    add_row(K_WR, 16'h0013, pc_r, C_IDLE, 0, "bp1_data");
    add_row(K_WR, 16'h0012, 32'h02, C_IDLE, 0, "bp1_fetch");
    add_row(K_EV, 0, pc_r, C_FETCH_FL, 0, "fetch_flushed");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 0, "hit_after_flush");
    add_row(K_EV, 0, pc_r, C_FETCH, 1, "fetch_hit");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 32'h20, "hit_bit5");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 0, "hit_cleared");
    add_row(K_WR, 16'h0012, 0, C_IDLE, 0, "bp1_off");
    ////////////////////
    // Memory breakpoints on slot 0
    adr_r = rand_word();
    add_row(K_WR, 16'h0011, adr_r, C_IDLE, 0, "bp0_data");
    add_row(K_WR, 16'h0010, 32'h42, C_IDLE, 0, "bp0_load");
    add_row(K_EV, 0, adr_r, C_LOAD_NOACK, 0, "load_no_dmem_ack");
    add_row(K_EV, 0, adr_r, C_LOAD_EXC, 0, "load_exception");
    add_row(K_EV, 0, adr_r, C_STORE, 0, "store_on_load_bp");
    add_row(K_EV, 0, adr_r ^ 32'h4, C_LOAD, 0, "load_other_adr");
    add_row(K_EV, 0, adr_r, C_LOAD, 1, "load_hit");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 32'h10, "hit_bit4");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_WR, 16'h0010, 32'h52, C_IDLE, 0, "bp0_store");
    add_row(K_EV, 0, adr_r, C_LOAD, 0, "load_on_store_bp");
    add_row(K_EV, 0, adr_r, C_STORE, 1, "store_hit");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_WR, 16'h0010, 32'h72, C_IDLE, 0, "bp0_ldst");
    add_row(K_EV, 0, adr_r, C_LOAD, 1, "ldst_load_hit");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_EV, 0, adr_r, C_STORE, 1, "ldst_store_hit");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_WR, 16'h0010, 0, C_IDLE, 0, "bp0_off");
    ////////////////////
    // Single-step and branch break
    add_row(K_WR, 16'h0000, 32'h1, C_IDLE, 0, "step_on");
    add_row(K_EV, 0, 0, C_INSTR, 1, "step_hit");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 32'h1, "hit_bit0");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_WR, 16'h0000, 32'h2, C_IDLE, 0, "branch_on");
    add_row(K_EV, 0, 0, C_INSTR, 0, "non_branch");
    add_row(K_EV, 0, 0, C_BRANCH, 1, "branch_hit");
    add_row(K_RD, 16'h0001, 0, C_IDLE, 32'h2, "hit_bit1");
    add_row(K_WR, 16'h0001, 0, C_IDLE, 0, "hit_clear");
    add_row(K_WR, 16'h0000, 0, C_IDLE, 0, "ctrl_off");
    ////////////////////
    // Cause and flush
    exc_r = (rand_word() & 32'hfff0_fff0) | 32'h0000_8000;
    add_row(K_EV, 0, 32'h0000_0a00, C_EXC, 1, "trap_event");
    add_row(K_RD, 16'h0003, 0, C_IDLE, cause_of(32'h0000_0a00), "cause_trap");
    add_row(K_EV, 0, 32'h0024_0000, C_EXC, 1, "intr_event");
    add_row(K_RD, 16'h0003, 0, C_IDLE, cause_of(32'h0024_0000), "cause_intr");
    add_row(K_EV, 0, exc_r, C_EXC, 1, "mixed_event");
    add_row(K_RD, 16'h0003, 0, C_IDLE, cause_of(exc_r), "cause_mixed");
    add_row(K_FLUSH, 0, 32'h0000_0004, C_STALL, 1, "stall_release_flush");
  endtask

  // Run limit from the table length
  initial
  begin
    wait (n_rows > 0);
    repeat (n_rows * 20 + 50) @(posedge clk);
    $display("Watchdog expired before all rows finished");
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    rstn = 1'b0;
    dbg_strb = 1'b0;
    dbg_we = 1'b0;
    dbg_addr = '0;
    dbg_dati = '0;
    ex_stall = 1'b0;
    apply_core(C_IDLE, 32'h0);
    build_table();
    n_rows = kind_q.size();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    repeat (2) @(negedge clk);
    for (int r = 0; r < n_rows; r++)
    begin
      row_err = 0;
      run_row(r);
      $display("%-22s %s", name_q[r], row_err ? "error" : "ok");
    end
    $display("%0d tests run, %0d errors", n_rows, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
du_pkg.sv
du_host_port.sv
du_regs.sv
du_bp_slot.sv
riscv_du.sv
du_assertions.sv
du_tb.sv

//--- Bender.yml
package:
  name: riscv_du

sources:
  - du_pkg.sv
  - du_host_port.sv
  - du_regs.sv
  - du_bp_slot.sv
  - riscv_du.sv
  - target: simulation
    files:
      - du_assertions.sv
      - du_tb.sv
